//--- exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// operand and result width
`define EXU_XLEN 64

// width of the rv64 word forms
`define EXU_WORD_W 32

// accumulation stages in the multiplier chain, must divide EXU_XLEN
`define EXU_MUL_STAGES 4

// multiplier bits consumed by each stage
`define EXU_MUL_SLICE (`EXU_XLEN / `EXU_MUL_STAGES)

`endif

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] func3_t;

  // base opcodes
  localparam opcode_t op_r_type = 7'b0110011;
  localparam opcode_t op_i_type = 7'b0010011;
  localparam opcode_t op_rv64_r = 7'b0111011;
  localparam opcode_t op_rv64_i = 7'b0011011;
  localparam opcode_t op_b_type = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_lui    = 7'b0110111;

  // integer register and immediate ops
  localparam func3_t f3_add  = 3'b000;
  localparam func3_t f3_sll  = 3'b001;
  localparam func3_t f3_slt  = 3'b010;
  localparam func3_t f3_sltu = 3'b011;
  localparam func3_t f3_xor  = 3'b100;
  localparam func3_t f3_srl  = 3'b101;
  localparam func3_t f3_or   = 3'b110;
  localparam func3_t f3_and  = 3'b111;

  // branch conditions
  localparam func3_t f3_beq  = 3'b000;
  localparam func3_t f3_bne  = 3'b001;
  localparam func3_t f3_blt  = 3'b100;
  localparam func3_t f3_bge  = 3'b101;
  localparam func3_t f3_bltu = 3'b110;
  localparam func3_t f3_bgeu = 3'b111;

  // M extension multiplies
  localparam func3_t f3_mul    = 3'b000;
  localparam func3_t f3_mulh   = 3'b001;
  localparam func3_t f3_mulhsu = 3'b010;
  localparam func3_t f3_mulhu  = 3'b011;

endpackage

//--- exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0]   word_t;
  typedef logic [`EXU_WORD_W-1:0] half_t;
  typedef logic [2*`EXU_XLEN-1:0] dword_t;  // full product

  typedef enum logic [3:0] {
    mode_none,
    mode_add,
    mode_sub,
    mode_and,
    mode_or,
    mode_xor,
    mode_sll,
    mode_srl,
    mode_sra,
    mode_slt,     // slt and sltu, func3 picks
    mode_pass_b,
    mode_branch
  } alu_mode_t;

  typedef enum logic [2:0] {
    mul_lo,
    mul_hi_ss,
    mul_hi_su,
    mul_hi_uu,
    mul_word,
    mul_none
  } mul_kind_t;

endpackage

//--- alu_mode_decode.sv
`timescale 1ns/1ps

module alu_mode_decode import exu_pkg::*, rv_isa_pkg::*; (
  input  opcode_t   opcode,
  input  func3_t    func3,
  input  logic      func7,
  output alu_mode_t mode,
  output logic      word_op
);

  alu_mode_t shr_mode;

  assign shr_mode = func7 ? mode_sra : mode_srl;  // bit 30 picks arithmetic shift
  assign word_op  = (opcode == op_rv64_r) || (opcode == op_rv64_i);

  always_comb begin
    case (opcode)
      op_r_type: begin
        case (func3)
          f3_add:  mode = func7 ? mode_sub : mode_add;
          f3_sll:  mode = mode_sll;
          f3_slt:  mode = mode_slt;
          f3_sltu: mode = mode_slt;
          f3_xor:  mode = mode_xor;
          f3_srl:  mode = shr_mode;
          f3_or:   mode = mode_or;
          f3_and:  mode = mode_and;
          default: mode = mode_none;
        endcase
      end
      op_i_type: begin
        case (func3)
          f3_add:  mode = mode_add;  // no subi
          f3_sll:  mode = mode_sll;
          f3_slt:  mode = mode_slt;
          f3_sltu: mode = mode_slt;
          f3_xor:  mode = mode_xor;
          f3_srl:  mode = shr_mode;
          f3_or:   mode = mode_or;
          f3_and:  mode = mode_and;
          default: mode = mode_none;
        endcase
      end
      op_rv64_r: begin
        case (func3)
          f3_add:  mode = func7 ? mode_sub : mode_add;
          f3_sll:  mode = mode_sll;
          f3_srl:  mode = shr_mode;
          default: mode = mode_none;
        endcase
      end
      op_rv64_i: begin
        case (func3)
          f3_add:  mode = mode_add;
          f3_sll:  mode = mode_sll;
          f3_srl:  mode = shr_mode;
          default: mode = mode_none;
        endcase
      end
      op_b_type: mode = mode_branch;
      op_load,
      op_store,
      op_jal,
      op_jalr,
      op_auipc:  mode = mode_add;    // address sums
      op_lui:    mode = mode_pass_b;
      default:   mode = mode_none;
    endcase
  end

endmodule

//--- mul_prep.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module mul_prep import exu_pkg::*, rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word_t     scr1,
  input  word_t     scr2,
  input  func3_t    func3,
  input  logic      word_op,
  input  logic      mul_en,
  input  logic      mul_ready,
  output logic      stg_valid,
  output logic      stg_neg,
  output word_t     stg_mcand,
  output word_t     stg_mplier,
  output dword_t    stg_acc,
  output mul_kind_t stg_kind
);

  mul_kind_t kind;
  logic      busy;
  logic      launch;
  logic      a_signed;
  logic      b_signed;
  half_t     a_lo;
  half_t     b_lo;
  word_t     a_mag;
  word_t     b_mag;

  assign launch   = mul_en & ~busy;
  assign a_signed = (kind == mul_hi_ss) || (kind == mul_hi_su);
  assign b_signed = (kind == mul_hi_ss);
  assign a_lo     = scr1[`EXU_WORD_W-1:0];
  assign b_lo     = scr2[`EXU_WORD_W-1:0];

  always_comb begin
    if (word_op) begin
      kind = (func3 == f3_mul) ? mul_word : mul_none;
    end else begin
      case (func3)
        f3_mul:    kind = mul_lo;
        f3_mulh:   kind = mul_hi_ss;
        f3_mulhsu: kind = mul_hi_su;
        f3_mulhu:  kind = mul_hi_uu;
        default:   kind = mul_none;  // div/rem not supported
      endcase
    end
  end

  always_comb begin
    if (kind == mul_word) begin
      a_mag = word_t'(a_lo);  // low product bits ignore sign
      b_mag = word_t'(b_lo);
    end else begin
      a_mag = (a_signed && scr1[`EXU_XLEN-1]) ? -scr1 : scr1;
      b_mag = (b_signed && scr2[`EXU_XLEN-1]) ? -scr2 : scr2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= launch;
      if (mul_ready) busy <= 1'b0;
      else if (launch) busy <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      stg_mcand  <= a_mag;
      stg_mplier <= b_mag;
      stg_acc    <= '0;
      stg_neg    <= (a_signed & scr1[`EXU_XLEN-1]) ^ (b_signed & scr2[`EXU_XLEN-1]);
      stg_kind   <= kind;
    end
  end

endmodule

//--- mul_stage.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module mul_stage import exu_pkg::*; #(
  parameter int STAGE_INDEX = 0
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      prev_valid,
  input  word_t     prev_mcand,
  input  word_t     prev_mplier,
  input  dword_t    prev_acc,
  input  logic      prev_neg,
  input  mul_kind_t prev_kind,
  output logic      next_valid,
  output word_t     next_mcand,
  output word_t     next_mplier,
  output dword_t    next_acc,
  output logic      next_neg,
  output mul_kind_t next_kind
);

  localparam int BASE = STAGE_INDEX * `EXU_MUL_SLICE;  // weight of this slice

  dword_t sum;

  always_comb begin
    sum = prev_acc;
    for (int j = 0; j < `EXU_MUL_SLICE; j++) begin
      if (prev_mplier[j]) sum = sum + (dword_t'(prev_mcand) << (BASE + j));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) next_valid <= 1'b0;
    else next_valid <= prev_valid;
  end

  always_ff @(posedge clk) begin
    next_mcand  <= prev_mcand;
    next_mplier <= prev_mplier >> `EXU_MUL_SLICE;  // drop consumed bits
    next_acc    <= sum;
    next_neg    <= prev_neg;
    next_kind   <= prev_kind;
  end

endmodule

//--- mul_finish.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module mul_finish import exu_pkg::*; (
  input  logic      valid,
  input  logic      neg,
  input  dword_t    acc,
  input  mul_kind_t kind,
  output word_t     mul_result,
  output logic      mul_ready
);

  dword_t prod;
  half_t  lo_word;
  word_t  formatted;

  // magnitudes were multiplied, put the sign back
  assign prod    = neg ? -acc : acc;
  assign lo_word = prod[`EXU_WORD_W-1:0];

  always_comb begin
    case (kind)
      mul_lo: begin
        formatted = prod[`EXU_XLEN-1:0];
      end
      mul_hi_ss,
      mul_hi_su,
      mul_hi_uu: begin
        formatted = prod[2*`EXU_XLEN-1:`EXU_XLEN];
      end
      mul_word: begin
        formatted = {{(`EXU_XLEN-`EXU_WORD_W){lo_word[`EXU_WORD_W-1]}}, lo_word};
      end
      default: begin
        formatted = '0;  // mul_none
      end
    endcase
  end

  assign mul_result = valid ? formatted : '0;
  assign mul_ready  = valid;

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module alu import exu_pkg::*, rv_isa_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  word_t   scr1,
  input  word_t   scr2,
  input  opcode_t opcode,
  input  func3_t  func3,
  input  logic    func7,
  input  logic    mul_en,
  output logic    mul_stall,
  output word_t   result
);

  localparam int N = `EXU_MUL_STAGES;

  alu_mode_t  mode;
  logic       word_op;
  logic [5:0] shamt;
  word_t      srl_src;
  word_t      sra_src;
  word_t      alu_res;
  word_t      word_ext;
  word_t      mul_result;
  half_t      alu_lo;
  logic       mul_ready;
  logic       lt_s;
  logic       lt_u;
  logic       take;

  logic      stg_valid  [0:N];
  word_t     stg_mcand  [0:N];
  word_t     stg_mplier [0:N];
  dword_t    stg_acc    [0:N];
  logic      stg_neg    [0:N];
  mul_kind_t stg_kind   [0:N];

  alu_mode_decode u_decode (
    .opcode(opcode), .func3(func3), .func7(func7), .mode(mode), .word_op(word_op)
  );

  // word forms shift the low half only, upper bits prepared for srl/sra
  assign shamt   = word_op ? {1'b0, scr2[4:0]} : scr2[5:0];
  assign srl_src = word_op ? word_t'(scr1[`EXU_WORD_W-1:0]) : scr1;
  assign sra_src = word_op ? {{(`EXU_XLEN-`EXU_WORD_W){scr1[`EXU_WORD_W-1]}},
                              scr1[`EXU_WORD_W-1:0]} : scr1;
  assign lt_s    = $signed(scr1) < $signed(scr2);
  assign lt_u    = scr1 < scr2;

  always_comb begin
    case (func3)
      f3_beq:  take = (scr1 == scr2);
      f3_bne:  take = (scr1 != scr2);
      f3_blt:  take = lt_s;
      f3_bge:  take = ~lt_s;
      f3_bltu: take = lt_u;
      f3_bgeu: take = ~lt_u;
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    case (mode)
      mode_add:    alu_res = scr1 + scr2;
      mode_sub:    alu_res = scr1 - scr2;
      mode_and:    alu_res = scr1 & scr2;
      mode_or:     alu_res = scr1 | scr2;
      mode_xor:    alu_res = scr1 ^ scr2;
      mode_sll:    alu_res = scr1 << shamt;
      mode_srl:    alu_res = srl_src >> shamt;
      mode_sra:    alu_res = $signed(sra_src) >>> shamt;
      mode_slt:    alu_res = word_t'((func3 == f3_sltu) ? lt_u : lt_s);
      mode_pass_b: alu_res = scr2;  // lui
      mode_branch: alu_res = word_t'(take);
      default:     alu_res = '0;
    endcase
  end

  assign alu_lo   = alu_res[`EXU_WORD_W-1:0];
  assign word_ext = {{(`EXU_XLEN-`EXU_WORD_W){alu_lo[`EXU_WORD_W-1]}}, alu_lo};

  mul_prep u_prep (
    .clk(clk), .reset(reset), .scr1(scr1), .scr2(scr2), .func3(func3),
    .word_op(word_op), .mul_en(mul_en), .mul_ready(mul_ready),
    .stg_valid(stg_valid[0]), .stg_neg(stg_neg[0]), .stg_mcand(stg_mcand[0]),
    .stg_mplier(stg_mplier[0]), .stg_acc(stg_acc[0]), .stg_kind(stg_kind[0])
  );

  for (genvar i = 0; i < N; i++) begin : g_stage
    mul_stage #(.STAGE_INDEX(i)) u_stage (
      .clk(clk), .reset(reset),
      .prev_valid(stg_valid[i]), .prev_mcand(stg_mcand[i]), .prev_mplier(stg_mplier[i]),
      .prev_acc(stg_acc[i]), .prev_neg(stg_neg[i]), .prev_kind(stg_kind[i]),
      .next_valid(stg_valid[i+1]), .next_mcand(stg_mcand[i+1]),
      .next_mplier(stg_mplier[i+1]), .next_acc(stg_acc[i+1]),
      .next_neg(stg_neg[i+1]), .next_kind(stg_kind[i+1])
    );
  end

  mul_finish u_finish (
    .valid(stg_valid[N]), .neg(stg_neg[N]), .acc(stg_acc[N]), .kind(stg_kind[N]),
    .mul_result(mul_result), .mul_ready(mul_ready)
  );

  assign mul_stall = mul_en & ~mul_ready;
  assign result    = mul_en ? mul_result : (word_op ? word_ext : alu_res);

endmodule

//--- tb_alu.sv
`timescale 1ns/1ps
`include "exu_cfg.svh"

module tb_alu import exu_pkg::*, rv_isa_pkg::*; ();

  logic    clk;
  logic    reset;
  word_t   scr1;
  word_t   scr2;
  opcode_t opcode;
  func3_t  func3;
  logic    func7;
  logic    mul_en;
  logic    mul_stall;
  word_t   result;
  int      n_checks;

  alu dut0 (
    .clk(clk), .reset(reset), .scr1(scr1), .scr2(scr2), .opcode(opcode),
    .func3(func3), .func7(func7), .mul_en(mul_en), .mul_stall(mul_stall), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // expected value straight from the rv64im rules
  function automatic word_t ref_result(opcode_t op, func3_t f3, logic f7, word_t a, word_t b,
                                       logic men);
    logic [127:0]       prod;
    logic [31:0]        w;
    logic signed [31:0] sa32;
    logic               is_word;
    word_t              r;
    is_word = (op == op_rv64_r) || (op == op_rv64_i);
    sa32 = a[31:0];
    r = '0;
    w = '0;
    if (men) begin
      if (is_word) begin
        prod = {96'b0, a[31:0]} * {96'b0, b[31:0]};
        if (f3 == f3_mul) r = {{32{prod[31]}}, prod[31:0]};
      end else begin
        case (f3)
          f3_mul:    r = a * b;
          f3_mulh: begin
            prod = {{64{a[63]}}, a} * {{64{b[63]}}, b};
            r = prod[127:64];
          end
          f3_mulhsu: begin
            prod = {{64{a[63]}}, a} * {64'b0, b};
            r = prod[127:64];
          end
          f3_mulhu: begin
            prod = {64'b0, a} * {64'b0, b};
            r = prod[127:64];
          end
          default:   r = '0;  // no divider
        endcase
      end
    end else begin
      case (op)
        op_r_type, op_i_type: begin
          case (f3)
            3'b000: r = (op == op_r_type && f7) ? a - b : a + b;
            3'b001: r = a << b[5:0];
            3'b010: r = word_t'($signed(a) < $signed(b));
            3'b011: r = word_t'(a < b);
            3'b100: r = a ^ b;
            3'b101: begin
              if (f7) r = $signed(a) >>> b[5:0];
              else r = a >> b[5:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
          endcase
        end
        op_rv64_r, op_rv64_i: begin
          case (f3)
            3'b000: w = (op == op_rv64_r && f7) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'b001: w = a[31:0] << b[4:0];
            3'b101: begin
              if (f7) w = sa32 >>> b[4:0];
              else w = a[31:0] >> b[4:0];
            end
            default: w = '0;
          endcase
          r = {{32{w[31]}}, w};
        end
        op_b_type: begin
          case (f3)
            f3_beq:  r = word_t'(a == b);
            f3_bne:  r = word_t'(a != b);
            f3_blt:  r = word_t'($signed(a) < $signed(b));
            f3_bge:  r = word_t'($signed(a) >= $signed(b));
            f3_bltu: r = word_t'(a < b);
            f3_bgeu: r = word_t'(a >= b);
            default: r = '0;
          endcase
        end
        op_load, op_store, op_jal, op_jalr, op_auipc: r = a + b;
        op_lui:  r = b;
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (!mul_en) begin
        check_flag("mul_stall", mul_stall, 1'b0);
        check_word("result", result, ref_result(opcode, func3, func7, scr1, scr2, 1'b0));
        n_checks++;
      end else if (!mul_stall) begin
        check_word("result", result, ref_result(opcode, func3, func7, scr1, scr2, 1'b1));
        n_checks++;
      end
    end
  end

  function automatic word_t edge_word(int sel);
    case (sel % 8)
      0: return 64'h0;
      1: return 64'h1;
      2: return '1;
      3: return 64'h8000_0000_0000_0000;
      4: return 64'h7fff_ffff_ffff_ffff;
      5: return 64'h0000_0000_8000_0000;
      6: return 64'h0000_0000_7fff_ffff;
      default: return {$urandom(), $urandom()};
    endcase
  endfunction

  function automatic word_t pick_operand();
    if ($urandom() % 4 == 0) return edge_word(int'($urandom() % 8));
    return {$urandom(), $urandom()};
  endfunction

  task automatic drive(opcode_t op, func3_t f3, logic f7, word_t a, word_t b, logic men);
    @(posedge clk);
    #2;
    opcode = op;
    func3  = f3;
    func7  = f7;
    scr1   = a;
    scr2   = b;
    mul_en = men;
  endtask

  // launch one multiply and wait for its ready cycle
  task automatic run_mul(opcode_t op, func3_t f3, word_t a, word_t b);
    int stalls;
    stalls = 0;
    drive(op, f3, 1'b0, a, b, 1'b1);
    @(negedge clk);
    while (mul_stall) begin
      stalls++;
      if (stalls >= 20) stop_on_error("multiply never completed, mul_stall stuck high");
      @(negedge clk);
    end
    if (stalls != `EXU_MUL_STAGES + 1)
      stop_on_error($sformatf("multiply stalled for %0d cycles instead of %0d",
                              stalls, `EXU_MUL_STAGES + 1));
  endtask

  initial begin
    opcode_t ops [4];
    opcode_t addr_ops [5];
    void'($urandom(32'h67d0));
    ops = '{op_r_type, op_i_type, op_rv64_r, op_rv64_i};
    addr_ops = '{op_load, op_store, op_jal, op_jalr, op_auipc};
    n_checks = 0;
    reset  = 1'b1;
    scr1   = '0;
    scr2   = '0;
    opcode = '0;
    func3  = '0;
    func7  = 1'b0;
    mul_en = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    check_flag("mul_stall", mul_stall, 1'b0);
    for (int k = 0; k < 400; k++)
      drive(ops[$urandom() % 4], func3_t'($urandom()), logic'($urandom()),
            pick_operand(), pick_operand(), 1'b0);
    for (int i = 0; i < 7; i++) begin  // compares on equal and boundary pairs
      for (int j = 0; j < 7; j++) begin
        for (int f = 0; f < 8; f++) drive(op_b_type, func3_t'(f), 1'b0,
                                          edge_word(i), edge_word(j), 1'b0);
        drive(op_r_type, f3_slt, 1'b0, edge_word(i), edge_word(j), 1'b0);
        drive(op_r_type, f3_sltu, 1'b0, edge_word(i), edge_word(j), 1'b0);
        drive(op_i_type, f3_slt, 1'b0, edge_word(i), edge_word(j), 1'b0);
        drive(op_i_type, f3_sltu, 1'b0, edge_word(i), edge_word(j), 1'b0);
      end
    end
    for (int k = 0; k < 40; k++) begin
      drive(addr_ops[$urandom() % 5], func3_t'($urandom()), 1'b0,
            pick_operand(), pick_operand(), 1'b0);
      drive(op_lui, func3_t'($urandom()), 1'b0, pick_operand(), pick_operand(), 1'b0);
    end
    for (int k = 0; k < 12; k++) begin
      for (int f = 0; f < 8; f++) begin
        run_mul(op_r_type, func3_t'(f), pick_operand(), pick_operand());
        drive(op_i_type, f3_add, 1'b0, '0, '0, 1'b0);
      end
      run_mul(op_rv64_r, f3_mul, pick_operand(), pick_operand());
      run_mul(op_rv64_r, f3_mulh, pick_operand(), pick_operand());  // no mulhw, gives zero
      drive(op_i_type, f3_add, 1'b0, '0, '0, 1'b0);
    end
    for (int k = 0; k < 10; k++) begin  // mul_en held high throughout
      run_mul(op_r_type, func3_t'($urandom() % 4), pick_operand(), pick_operand());
      run_mul(op_rv64_r, f3_mul, pick_operand(), pick_operand());
    end
    drive(op_i_type, f3_add, 1'b0, '0, '0, 1'b0);
    @(negedge clk);
    if (n_checks == 0) begin
      stop_on_error("no result was ever compared");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+.
rv_isa_pkg.sv
exu_pkg.sv
alu_mode_decode.sv
mul_prep.sv
mul_stage.sv
mul_finish.sv
alu.sv
tb_alu.sv

//--- run_sim.sh
#!/bin/bash
# build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module tb_alu -f verilog.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_alu > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log && echo "simulation passed" \
  || { echo "simulation ended without a result"; exit 1; }
